//--- Makefile
# Verilator build and run of the pc redirect unit testbench

all: run

# rebuilt only when a listed source or the list itself changes
obj_dir/Vpc_redirect_tb: verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert -j 0 --top-module pc_redirect_tb -f verilog.f

# pass only when the pass line shows up in the output
run: obj_dir/Vpc_redirect_tb
	@out=$$(./obj_dir/Vpc_redirect_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean

//--- logic/branch_predecode.sv
// decode stage of the redirect unit
// classifies the fetched word as branch, JAL or neither
// and produces the sign-extended pc offset, purely combinational

`timescale 1ns/1ps

module branch_predecode
    import rv_isa_pkg::*, pc_flow_pkg::*;
(
    input  fetch_slot_t slot,
    output predecode_t  predec
);

    // same word, two field views
    instr_word_u word;

    logic        op_branch;
    logic        op_jal;
    logic [31:0] imm_b;
    logic [31:0] imm_j;

    assign word = slot.instr;

    // opcode bits coincide in both views
    assign op_branch = (word.b.opcode == opcode_branch);
    assign op_jal    = (word.j.opcode == opcode_jal);

    // B immediate
    // sign from bit 31, bit 11 comes from instr bit 7
    assign imm_b = {
        {19{word.b.imm12}},
        word.b.imm12,
        word.b.imm11,
        word.b.imm10_5,
        word.b.imm4_1,
        1'b0
    };

    // J immediate
    // the 19:12 field sits ahead of bit 11 in the word
    assign imm_j = {
        {11{word.j.imm20}},
        word.j.imm20,
        word.j.imm19_12,
        word.j.imm11,
        word.j.imm10_1,
        1'b0
    };

    // pick the offset matching the format
    // anything else just steps to the next word
    always_comb begin
        predec.is_branch = op_branch;
        predec.is_jal    = op_jal;
        if (op_branch) begin
            predec.offset = imm_b;
        end else if (op_jal) begin
            predec.offset = imm_j;
        end else begin
            predec.offset = pc_step;
        end
    end

    // funct3 is not checked
    // every branch condition shares the target math
    // JALR goes through execute, not here

    // valid is left to the execute stage
    // the flags only say what the word looks like

endmodule

//--- logic/next_pc_calc.sv
// execute stage of the redirect unit
// checks the committing branch for a misprediction and
// picks base and offset for the one target adder

`timescale 1ns/1ps

module next_pc_calc
    import pc_flow_pkg::*;
(
    input  fetch_slot_t  slot,
    input  predecode_t   predec,
    input  commit_info_t commit,
    output redirect_t    next_redirect
);

    logic        mispredict;
    logic        wrong_taken;
    logic        fetch_jump;
    logic [31:0] base;
    logic [31:0] offset;

    // commit path
    // only a real branch with differing directions counts
    assign mispredict = commit.valid & commit.is_branch &
                        (commit.pred_taken ^ commit.actual_taken);

    // predicted taken but fell through
    assign wrong_taken = commit.pred_taken & ~commit.actual_taken;

    // fetch path
    // JAL always jumps, a branch only when predicted taken
    assign fetch_jump = predec.is_jal | (predec.is_branch & slot.pred_taken);

    always_comb begin
        if (mispredict) begin
            // recover from the committing branch
            // fetch slot this cycle is on the wrong path
            base = commit.pc;
            if (wrong_taken) begin
                offset = pc_step;
            end else begin
                offset = commit.imm_se;
            end
        end else begin
            base = slot.pc;
            if (fetch_jump) begin
                offset = predec.offset;
            end else begin
                offset = pc_step;
            end
        end
    end

    // single adder shared by every case
    // wraps modulo 2^32 like the pc itself
    assign next_redirect.pc = base + offset;

    // a mispredict redirects even with no fetch slot
    assign next_redirect.valid = mispredict | slot.valid;

    // flush ROB and issue queue on recovery only
    assign next_redirect.flush = mispredict;

    // pc is don't-care while valid is low
    // the register stage keeps it anyway

    // correct predictions and non-branch commits
    // leave the fetch path untouched

endmodule

//--- logic/pc_flow_pkg.sv
// records passed between fetch, commit and the redirect stages
// plus the sequential pc increment
// import into every stage of the redirect unit

package pc_flow_pkg;

    import rv_isa_pkg::*;

    // fall-through increment, no compressed instructions
    localparam logic [31:0] pc_step = 32'd4;

    // one fetched slot, valid for a single cycle per item
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        instr_word_u instr;
        logic        pred_taken;
    } fetch_slot_t;

    // head of the reorder buffer as it commits
    // imm_se already sign extended by the decoder upstream
    typedef struct packed {
        logic        valid;
        logic        is_branch;
        logic [31:0] pc;
        logic [31:0] imm_se;
        logic        pred_taken;
        logic        actual_taken;
    } commit_info_t;

    // decode result handed to the execute stage
    typedef struct packed {
        logic        is_branch;
        logic        is_jal;
        logic [31:0] offset;
    } predecode_t;

    // chosen next pc, flush pulses only on a mispredict
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        flush;
    } redirect_t;

endpackage

//--- logic/pc_redirect_unit.sv
// top level of the next-pc redirect unit
// fetch slot and commit info in, registered redirect out
// decode and execute are combinational, result is one flop stage

`timescale 1ns/1ps

module pc_redirect_unit
    import pc_flow_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  fetch_slot_t  fetch,
    input  commit_info_t commit,
    input  logic         issue_queue_full,
    output redirect_t    redirect,
    output logic         pc_write_en
);

    // decode to execute
    predecode_t predec;
    // execute to result
    redirect_t  next_redirect;

    // classify the fetched word
    branch_predecode i_branch_predecode (
        .slot   (fetch),
        .predec (predec)
    );

    // commit mispredict wins over the fetch slot
    next_pc_calc i_next_pc_calc (
        .slot          (fetch),
        .predec        (predec),
        .commit        (commit),
        .next_redirect (next_redirect)
    );

    // flop stage and write enable gating
    redirect_register i_redirect_register (
        .clk              (clk),
        .rst_n            (rst_n),
        .next_redirect    (next_redirect),
        .issue_queue_full (issue_queue_full),
        .redirect         (redirect),
        .pc_write_en      (pc_write_en)
    );

endmodule

//--- logic/redirect_register.sv
// result stage of the redirect unit
// registers the chosen redirect and the flush pulse
// and derives the pc write enable from issue queue fullness

`timescale 1ns/1ps

module redirect_register
    import pc_flow_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  redirect_t next_redirect,
    input  logic      issue_queue_full,
    output redirect_t redirect,
    output logic      pc_write_en
);

    // fullness sampled alongside the redirect
    logic iq_full_q;

    // one flop stage, exactly one cycle of latency
    // flush reloads every cycle so it lasts a single cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect  <= '0;
            iq_full_q <= 1'b0;
        end else begin
            redirect  <= next_redirect;
            iq_full_q <= issue_queue_full;
        end
    end

    // full queue blocks the pc update
    // a flush empties the queue next cycle, so recovery writes anyway
    assign pc_write_en = redirect.valid & (~iq_full_q | redirect.flush);

    // the redirect itself is reported even when blocked
    // no back-pressure towards fetch or ROB

endmodule

//--- logic/rv_isa_pkg.sv
// RV32I instruction encodings used by the front end predecode
// import into any module that inspects a raw fetched word
// the B and J field views overlay the same 32 bits

package rv_isa_pkg;

    // major opcodes, bits 6:0 of every base instruction
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_jal    = 7'b1101111;

    // B-type layout, imm[12|10:5] rs2 rs1 funct3 imm[4:1|11] opcode
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } instr_fmt_b_t;

    // J-type layout, imm[20|10:1|11|19:12] rd opcode
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fmt_j_t;

    // one fetched word, read as raw bits or through either format
    // decode pulls both immediates before the opcode is known
    typedef union packed {
        logic [31:0]  raw;
        instr_fmt_b_t b;
        instr_fmt_j_t j;
    } instr_word_u;

    // opcode sits in the same bits in both views
    // so either field may be compared

    // B immediate range is +-4 KiB, J immediate is +-1 MiB
    // bit 0 of both is implied zero

endpackage

//--- verification/pc_redirect_assert.sv
// concurrent checks on the redirect result stage
// attached to every redirect_register through the bind at the bottom

`timescale 1ns/1ps

module pc_redirect_assert
    import pc_flow_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input redirect_t next_redirect,
    input logic      issue_queue_full,
    input redirect_t redirect,
    input logic      pc_write_en
);

    // flush only rides on a valid redirect
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect.flush |-> redirect.valid)
        else $error("flush raised without a valid redirect");

    // a second flush cycle needs a new mispredict behind it
    assert property (@(posedge clk) disable iff (!rst_n)
        (redirect.flush && !next_redirect.flush) |=> !redirect.flush)
        else $error("flush held without a fresh mispredict");

    // outputs still at reset values on the first edge after release
    assert property (@(posedge clk)
        $rose(rst_n) |-> (!redirect.valid && !redirect.flush &&
                          (redirect.pc == 32'h0) && !pc_write_en))
        else $error("outputs not cleared after reset");

    // pc write needs a valid redirect and a queue that was not full
    // a flushing redirect writes regardless
    assert property (@(posedge clk) disable iff (!rst_n)
        pc_write_en |-> (redirect.valid && (redirect.flush || !$past(issue_queue_full))))
        else $error("pc write enable without a valid redirect or with the queue full");

endmodule

bind redirect_register pc_redirect_assert i_pc_redirect_assert (
    .clk              (clk),
    .rst_n            (rst_n),
    .next_redirect    (next_redirect),
    .issue_queue_full (issue_queue_full),
    .redirect         (redirect),
    .pc_write_en      (pc_write_en)
);

//--- verification/pc_redirect_tb.sv
// directed testbench for the next-pc redirect unit
// drives fetch slots, commits and queue fullness on the falling edge
// and checks every registered redirect one cycle later

`timescale 1ns/1ps

module pc_redirect_tb
    import rv_isa_pkg::*, pc_flow_pkg::*;
;

    logic         clk;
    logic         rst_n;
    fetch_slot_t  fetch;
    commit_info_t commit;
    logic         issue_queue_full;
    redirect_t    redirect;
    logic         pc_write_en;

    // random stream state
    logic [31:0]  lcg_state;

    pc_redirect_unit i_pc_redirect_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch            (fetch),
        .commit           (commit),
        .issue_queue_full (issue_queue_full),
        .redirect         (redirect),
        .pc_write_en      (pc_write_en)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // reset held for 10 rising edges, released on a falling edge
    initial begin
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // B-type word, beq x1, x2 with the given 13-bit offset
    function automatic logic [31:0] encode_b(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], opcode_branch};
    endfunction

    // J-type word, jal x1 with the given 21-bit offset
    function automatic logic [31:0] encode_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, opcode_jal};
    endfunction

    function automatic fetch_slot_t make_slot(
        input logic [31:0] pc,
        input logic [31:0] word,
        input logic        pred_taken
    );
        fetch_slot_t s;
        s            = '0;
        s.valid      = 1'b1;
        s.pc         = pc;
        s.instr.raw  = word;
        s.pred_taken = pred_taken;
        return s;
    endfunction

    function automatic commit_info_t make_commit(
        input logic [31:0] pc,
        input logic [31:0] imm_se,
        input logic        is_branch,
        input logic        pred_taken,
        input logic        actual_taken
    );
        commit_info_t c;
        c.valid        = 1'b1;
        c.is_branch    = is_branch;
        c.pc           = pc;
        c.imm_se       = imm_se;
        c.pred_taken   = pred_taken;
        c.actual_taken = actual_taken;
        return c;
    endfunction

    function automatic redirect_t expect_redirect(
        input logic        valid,
        input logic [31:0] pc,
        input logic        flush
    );
        redirect_t r;
        r.valid = valid;
        r.pc    = pc;
        r.flush = flush;
        return r;
    endfunction

    // reference model, immediates straight from the ISA bit positions
    function automatic redirect_t ref_redirect(input fetch_slot_t f, input commit_info_t c);
        redirect_t   r;
        logic [31:0] w;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        mis;
        w     = f.instr.raw;
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        mis   = c.valid && c.is_branch && (c.pred_taken != c.actual_taken);
        r     = '0;
        if (mis) begin
            r.valid = 1'b1;
            r.flush = 1'b1;
            // wrongly taken falls through, wrongly not-taken jumps
            r.pc    = c.pred_taken ? c.pc + 32'd4 : c.pc + c.imm_se;
        end else if (f.valid) begin
            r.valid = 1'b1;
            if (w[6:0] == opcode_jal) begin
                r.pc = f.pc + imm_j;
            end else if (w[6:0] == opcode_branch && f.pred_taken) begin
                r.pc = f.pc + imm_b;
            end else begin
                r.pc = f.pc + 32'd4;
            end
        end
        return r;
    endfunction

    // full queue blocks the write unless the redirect flushes
    function automatic logic ref_write_en(input redirect_t r, input logic full);
        return r.valid && (!full || r.flush);
    endfunction

    task automatic compare_redirect(
        input redirect_t exp,
        input redirect_t got,
        input logic      check_pc,
        input string     what
    );
        logic bad;
        bad = (got.valid !== exp.valid) || (got.flush !== exp.flush) ||
              (check_pc && (got.pc !== exp.pc));
        if (bad) begin
            $display("MISMATCH at %0t: %s redirect expected v=%0b pc=%08h f=%0b",
                     $time, what, exp.valid, exp.pc, exp.flush);
            $display("MISMATCH at %0t: %s redirect got v=%0b pc=%08h f=%0b",
                     $time, what, got.valid, got.pc, got.flush);
            $display("tests failed");
            $fatal(1, "redirect mismatch");
        end
    endtask

    task automatic compare_write_en(input logic exp, input logic got, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s pc_write_en expected %0b got %0b",
                     $time, what, exp, got);
            $display("tests failed");
            $fatal(1, "write enable mismatch");
        end
    endtask

    // called on a falling edge, returns on the next one
    // inputs go idle again right before the checks
    task automatic drive_and_check(
        input fetch_slot_t  f,
        input commit_info_t c,
        input logic         full,
        input redirect_t    exp_redirect,
        input logic         exp_write_en,
        input string        what
    );
        fetch            = f;
        commit           = c;
        issue_queue_full = full;
        @(posedge clk);
        @(negedge clk);
        fetch            = '0;
        commit           = '0;
        issue_queue_full = 1'b0;
        // pc only meaningful while valid
        compare_redirect(exp_redirect, redirect, exp_redirect.valid, what);
        compare_write_en(exp_write_en, pc_write_en, what);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was still asserted after 40 cycles");
            $display("tests failed");
            $fatal(1, "reset timeout");
        end
    endtask

    task automatic test_sequential();
        // addi x1, x0, 5
        drive_and_check(make_slot(32'h1000, 32'h0050_0093, 1'b0), '0, 1'b0,
                        expect_redirect(1'b1, 32'h1004, 1'b0), 1'b1, "non-branch");
        drive_and_check(make_slot(32'h2000, encode_b(13'h0010), 1'b0), '0, 1'b0,
                        expect_redirect(1'b1, 32'h2004, 1'b0), 1'b1, "branch not taken");
        // top of the address space wraps to zero
        drive_and_check(make_slot(32'hFFFF_FFFC, 32'h0050_0093, 1'b1), '0, 1'b0,
                        expect_redirect(1'b1, 32'h0, 1'b0), 1'b1, "pc wrap");
    endtask

    task automatic test_taken_branches();
        drive_and_check(make_slot(32'h1000, encode_b(13'h0010), 1'b1), '0, 1'b0,
                        expect_redirect(1'b1, 32'h1010, 1'b0), 1'b1, "branch +16");
        drive_and_check(make_slot(32'h1000, encode_b(13'h1FF8), 1'b1), '0, 1'b0,
                        expect_redirect(1'b1, 32'h0FF8, 1'b0), 1'b1, "branch -8");
        // -4096, the most negative B offset
        drive_and_check(make_slot(32'h8000, encode_b(13'h1000), 1'b1), '0, 1'b0,
                        expect_redirect(1'b1, 32'h7000, 1'b0), 1'b1, "branch -4096");
        drive_and_check(make_slot(32'h8000, encode_b(13'h0FFE), 1'b1), '0, 1'b0,
                        expect_redirect(1'b1, 32'h8FFE, 1'b0), 1'b1, "branch +4094");
    endtask

    task automatic test_jal();
        // pred_taken has no say over a JAL
        drive_and_check(make_slot(32'h4000, encode_j(21'h01234), 1'b0), '0, 1'b0,
                        expect_redirect(1'b1, 32'h5234, 1'b0), 1'b1, "jal forward");
        drive_and_check(make_slot(32'h4000, encode_j(21'h1FFF00), 1'b1), '0, 1'b0,
                        expect_redirect(1'b1, 32'h3F00, 1'b0), 1'b1, "jal backward");
        drive_and_check(make_slot(32'h0010_0000, encode_j(21'h100000), 1'b0), '0, 1'b0,
                        expect_redirect(1'b1, 32'h0, 1'b0), 1'b1, "jal -1MiB");
    endtask

    task automatic test_commit_mispredict();
        commit_info_t c;
        drive_and_check('0, make_commit(32'h3000, 32'h40, 1'b1, 1'b1, 1'b0), 1'b0,
                        expect_redirect(1'b1, 32'h3004, 1'b1), 1'b1, "wrongly taken");
        drive_and_check('0, make_commit(32'h3000, 32'h40, 1'b1, 1'b0, 1'b1), 1'b0,
                        expect_redirect(1'b1, 32'h3040, 1'b1), 1'b1, "wrongly not taken");
        drive_and_check('0, make_commit(32'h3000, 32'hFFFF_FF00, 1'b1, 1'b0, 1'b1), 1'b0,
                        expect_redirect(1'b1, 32'h2F00, 1'b1), 1'b1, "wrongly not taken back");
        // differing bits on a non-branch are ignored
        drive_and_check('0, make_commit(32'h3000, 32'h40, 1'b0, 1'b1, 1'b0), 1'b0,
                        expect_redirect(1'b0, 32'h0, 1'b0), 1'b0, "non-branch commit");
        c       = make_commit(32'h3000, 32'h40, 1'b1, 1'b1, 1'b0);
        c.valid = 1'b0;
        drive_and_check('0, c, 1'b0,
                        expect_redirect(1'b0, 32'h0, 1'b0), 1'b0, "commit not valid");
        drive_and_check(make_slot(32'h1000, 32'h0050_0093, 1'b0),
                        make_commit(32'h3000, 32'h40, 1'b1, 1'b1, 1'b1), 1'b0,
                        expect_redirect(1'b1, 32'h1004, 1'b0), 1'b1, "correct prediction");
        // fetch slot on the wrong path is dropped
        drive_and_check(make_slot(32'h4000, encode_j(21'h01234), 1'b0),
                        make_commit(32'h3000, 32'h40, 1'b1, 1'b1, 1'b0), 1'b0,
                        expect_redirect(1'b1, 32'h3004, 1'b1), 1'b1, "mispredict over fetch");
    endtask

    task automatic test_write_enable();
        drive_and_check(make_slot(32'h1000, 32'h0050_0093, 1'b0), '0, 1'b1,
                        expect_redirect(1'b1, 32'h1004, 1'b0), 1'b0, "fetch queue full");
        drive_and_check('0, make_commit(32'h3000, 32'h40, 1'b1, 1'b1, 1'b0), 1'b1,
                        expect_redirect(1'b1, 32'h3004, 1'b1), 1'b1, "mispredict queue full");
        drive_and_check('0, '0, 1'b1,
                        expect_redirect(1'b0, 32'h0, 1'b0), 1'b0, "idle queue full");
        drive_and_check(make_slot(32'h1000, 32'h0050_0093, 1'b0), '0, 1'b0,
                        expect_redirect(1'b1, 32'h1004, 1'b0), 1'b1, "fetch queue free");
    endtask

    task automatic test_random_mix();
        fetch_slot_t  f;
        commit_info_t c;
        redirect_t    exp;
        logic [31:0]  r;
        logic [31:0]  word;
        logic [31:0]  imm;
        logic         full;
        for (int i = 0; i < 200; i++) begin
            // upper bits only, the low LCG bits cycle quickly
            r    = lcg_next();
            word = lcg_next();
            case (r[31:30])
                2'd0: word[6:0] = opcode_branch;
                2'd1: word[6:0] = opcode_jal;
                default: ;
            endcase
            f       = make_slot(lcg_next() & 32'hFFFF_FFFC, word, r[29]);
            f.valid = r[28];
            imm     = lcg_next();
            c       = make_commit(lcg_next() & 32'hFFFF_FFFC,
                                  {{19{imm[12]}}, imm[12:1], 1'b0}, r[27], r[26], r[25]);
            c.valid = r[24];
            full    = r[23];
            exp     = ref_redirect(f, c);
            drive_and_check(f, c, full, exp, ref_write_en(exp, full), "random mix");
        end
    endtask

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        fetch            = '0;
        commit           = '0;
        issue_queue_full = 1'b0;
        lcg_state        = 32'd68166;
        // outputs sit at their reset values while rst_n is low
        @(negedge clk);
        compare_redirect(expect_redirect(1'b0, 32'h0, 1'b0), redirect, 1'b1, "in reset");
        compare_write_en(1'b0, pc_write_en, "in reset");
        wait_reset_release();
        test_sequential();
        test_taken_branches();
        test_jal();
        test_commit_mispredict();
        test_write_enable();
        test_random_mix();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- verilog.f
logic/rv_isa_pkg.sv
logic/pc_flow_pkg.sv
logic/branch_predecode.sv
logic/next_pc_calc.sv
logic/redirect_register.sv
logic/pc_redirect_unit.sv
verification/pc_redirect_assert.sv
verification/pc_redirect_tb.sv
